// ==== src.f ====
+incdir+verif
common/posit_pkg.sv
posit_add/posit_decode.sv
posit_add/posit_align_add.sv
posit_add/posit_normalize.sv
verilog/posit_adder.sv
verif/tb_posit_adder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the posit adder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_posit_adder -Mdir obj_dir -f src.f \
    && ./obj_dir/Vtb_posit_adder > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

// ==== verif/posit_model.svh ====
`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

// Signed fixed point with FX bits below the binary point
// Holds minpos and twice maxpos without loss
localparam int FX = (N - 2) * (1 << ES) + N;

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'h0001;

// One LFSR step per bit taken, newest bit lowest
function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < nbits; i++)
    begin
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// Exact value of a posit in fixed point
// NaR reads as zero, callers test for it first
function automatic longint posit_value(input posit_t p);
    posit_t m;
    int run;
    int pos;
    int k;
    int e;
    int fb;
    longint f;
    longint v;
    m = p[N-1] ? -p : p;
    if (m == '0 || p == NAR)
    begin
        return 0;
    end
    run = 0;
    pos = N - 2;
    while (pos >= 0 && m[pos] == m[N-2])
    begin
        run = run + 1;
        pos = pos - 1;
    end
    // Run of ones gives k = run - 1, run of zeros gives k = -run
    k = m[N-2] ? run - 1 : -run;
    // Skip the bit that ends the run
    pos = pos - 1;
    e = 0;
    for (int i = 0; i < ES; i++)
    begin
        // Exponent bits cut off by a long regime count as zeros
        e = e * 2 + ((pos >= 0) ? int'(m[pos]) : 0);
        pos = pos - 1;
    end
    fb = (pos >= 0) ? pos + 1 : 0;
    // Hidden one on top of the fraction bits
    f = (longint'(1) <<< fb) | (longint'(m) & ((longint'(1) <<< fb) - 1));
    v = f <<< (k * (1 << ES) + e + FX - fb);
    return p[N-1] ? -v : v;
endfunction

// Largest posit magnitude not above the exact one, sign put back after
function automatic posit_t trunc_encode(input longint v);
    longint mag;
    posit_t best;
    mag = (v < 0) ? -v : v;
    best = '0;
    // Positive posits rise with their bit pattern
    for (int i = 1; i < (1 << (N - 1)); i++)
    begin
        if (posit_value(posit_t'(i)) <= mag)
        begin
            best = posit_t'(i);
        end
    end
    return (v < 0) ? -best : best;
endfunction

// Expected {inf, zero, sum} for one pair
function automatic logic [N+1:0] expected_of(input posit_t a, input posit_t b);
    logic both_zero;
    both_zero = (a == '0) && (b == '0);
    if (a == NAR || b == NAR)
    begin
        return {1'b1, 1'b0, NAR};
    end
    return {1'b0, both_zero, trunc_encode(posit_value(a) + posit_value(b))};
endfunction

// No NaR, and a nonzero sum between minpos and maxpos
function automatic logic in_range(input posit_t a, input posit_t b);
    longint s;
    if (a == NAR || b == NAR)
    begin
        return 1'b0;
    end
    s = posit_value(a) + posit_value(b);
    if (s < 0)
    begin
        s = -s;
    end
    return s == 0 || (s >= posit_value(posit_t'(1)) && s <= posit_value(~NAR));
endfunction

`endif

// ==== verif/tb_posit_adder.sv ====
module tb_posit_adder
    import posit_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = POSIT_N_DEF;
    localparam int ES = POSIT_ES_DEF;
    localparam int DRAIN_MAX = 200;
    localparam int PICK_MAX = 1000;

    typedef logic [N-1:0] posit_t;

    // Sign bit alone
    localparam posit_t NAR = {1'b1, {(N-1){1'b0}}};

    logic aclk;
    logic rst_i;
    posit_t a_i;
    posit_t b_i;
    logic start_i;
    posit_t sum_o;
    logic zero_o;
    logic inf_o;
    logic done_o;

    // Expected {inf, zero, sum} per start, oldest first
    logic [N+1:0] exp_q[$];
    posit_t exp_sum;
    logic exp_zero;
    logic exp_inf;

    // Starts shifted along beside the DUT
    logic [ADD_LAT-1:0] start_pipe;

    int err_cnt;
    int err_mark;
    int tests_run;
    int tests_failed;
    int ops;
    logic timed_out;

    `include "posit_model.svh"

    posit_adder i_dut (
        .aclk(aclk),
        .rst_i(rst_i),
        .a_i(a_i),
        .b_i(b_i),
        .start_i(start_i),
        .sum_o(sum_o),
        .zero_o(zero_o),
        .inf_o(inf_o),
        .done_o(done_o)
    );

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #4 aclk = ~aclk;
        end
    end

    always @(posedge aclk)
    begin
        if (rst_i)
        begin
            start_pipe <= '0;
        end
        else
        begin
            start_pipe <= {start_pipe[ADD_LAT-2:0], start_i};
        end
    end

    // Head of the scoreboard, stable before the edge that samples it
    always @(negedge aclk)
    begin
        if (done_o && exp_q.size() > 0)
        begin
            {exp_inf, exp_zero, exp_sum} = exp_q.pop_front();
        end
    end

    // Done exactly ADD_LAT cycles after each start, never on its own
    a_done_timing: assert property (@(posedge aclk) disable iff (rst_i)
        done_o == start_pipe[ADD_LAT-1])
    else
    begin
        $display("** Error at %0t: done_o is %0b, expected %0b", $time,
            $sampled(done_o), $sampled(start_pipe[ADD_LAT-1]));
        err_cnt++;
    end

    a_sum_value: assert property (@(posedge aclk) disable iff (rst_i)
        done_o |-> sum_o == exp_sum)
    else
    begin
        $display("** Error at %0t: sum_o is %h, expected %h", $time,
            $sampled(sum_o), $sampled(exp_sum));
        err_cnt++;
    end

    a_flags: assert property (@(posedge aclk) disable iff (rst_i)
        done_o |-> zero_o == exp_zero && inf_o == exp_inf)
    else
    begin
        $display("** Error at %0t: zero_o/inf_o are %0b/%0b, expected %0b/%0b", $time,
            $sampled(zero_o), $sampled(inf_o), $sampled(exp_zero), $sampled(exp_inf));
        err_cnt++;
    end

    // One start, expected result queued at the same time
    task automatic issue(input posit_t a, input posit_t b);
        a_i = a;
        b_i = b;
        start_i = 1'b1;
        exp_q.push_back(expected_of(a, b));
        ops++;
        @(posedge aclk);
        #1;
        start_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic pick_pair(output posit_t a, output posit_t b);
        int tries;
        tries = 0;
        do
        begin
            a = posit_t'(lfsr_take(N));
            b = posit_t'(lfsr_take(N));
            tries++;
        end
        while (!in_range(a, b) && tries < PICK_MAX);
    endtask

    // Neither zero nor NaR
    task automatic pick_operand(output posit_t x);
        int tries;
        tries = 0;
        do
        begin
            x = posit_t'(lfsr_take(N));
            tries++;
        end
        while ((x == '0 || x == NAR) && tries < PICK_MAX);
    endtask

    // Wait for every result of the test, then report it
    task automatic finish_test(input string name);
        int cnt;
        int errs;
        cnt = 0;
        while ((exp_q.size() != 0 || start_pipe != '0) && cnt < DRAIN_MAX)
        begin
            @(posedge aclk);
            #1;
            cnt++;
        end
        // One more edge so the last result has been checked
        @(posedge aclk);
        #1;
        if (cnt >= DRAIN_MAX)
        begin
            timed_out = 1'b1;
            $display("Timeout: test %s still missing %0d results after %0d cycles",
                name, exp_q.size(), DRAIN_MAX);
        end
        errs = err_cnt - err_mark;
        err_mark = err_cnt;
        tests_run++;
        if (errs != 0 || cnt >= DRAIN_MAX)
        begin
            tests_failed++;
        end
        $display("Test %-9s %4d additions %3d errors", name, ops, errs);
        ops = 0;
    endtask

    task automatic test_latency();
        posit_t a;
        posit_t b;
        pick_pair(a, b);
        issue(a, b);
        idle(8);
        // Overlapping, then back to back
        pick_pair(a, b);
        issue(a, b);
        idle(3);
        repeat (6)
        begin
            pick_pair(a, b);
            issue(a, b);
        end
        finish_test("latency");
    endtask

    task automatic test_zero();
        issue('0, '0);
        issue('0, '0);
        idle(2);
        issue('0, '0);
        finish_test("zero");
    endtask

    task automatic test_nar();
        posit_t x;
        pick_operand(x);
        issue(NAR, x);
        issue(x, NAR);
        issue(NAR, NAR);
        issue(NAR, '0);
        issue('0, NAR);
        finish_test("nar");
    endtask

    // x + 0, 0 + x and x + (-x)
    task automatic test_identity();
        posit_t x;
        repeat (10)
        begin
            pick_operand(x);
            issue(x, '0);
            issue('0, x);
            issue(x, -x);
        end
        finish_test("identity");
    endtask

    task automatic test_general();
        posit_t a;
        posit_t b;
        repeat (300)
        begin
            pick_pair(a, b);
            issue(a, b);
        end
        finish_test("general");
    endtask

    initial
    begin
        rst_i = 1'b1;
        a_i = '0;
        b_i = '0;
        start_i = 1'b0;
        exp_sum = '0;
        exp_zero = 1'b0;
        exp_inf = 1'b0;
        err_cnt = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        ops = 0;
        timed_out = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        rst_i = 1'b0;
        test_latency();
        if (!timed_out)
        begin
            test_zero();
        end
        if (!timed_out)
        begin
            test_nar();
        end
        if (!timed_out)
        begin
            test_identity();
        end
        if (!timed_out)
        begin
            test_general();
        end
        $display("Tests run %0d, failed %0d, assertion errors %0d",
            tests_run, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0 && !timed_out)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/posit_adder.sv ====
module posit_adder
    import posit_pkg::*;
#(
    parameter int N = POSIT_N_DEF,
    parameter int ES = POSIT_ES_DEF,
    localparam int BS = $clog2(N)
)
(
    input  logic         aclk,
    input  logic         rst_i,
    input  logic [N-1:0] a_i,
    input  logic [N-1:0] b_i,
    input  logic         start_i,
    output logic [N-1:0] sum_o,
    output logic         zero_o,
    output logic         inf_o,
    output logic         done_o
);

    typedef logic [BS-1:0] run_t;
    typedef logic [ES-1:0] exp_t;
    typedef logic [N-ES:0] frac_t;
    typedef logic [N-ES+1:0] sum_t;
    typedef logic signed [ES+BS+1:0] scale_t;

    // Decode to align-add
    logic d_lg_sign;
    logic d_op_add;
    logic d_lg_rc;
    run_t d_lg_regime;
    exp_t d_lg_exp;
    frac_t d_lg_frac;
    logic d_sm_rc;
    run_t d_sm_regime;
    exp_t d_sm_exp;
    frac_t d_sm_frac;
    logic d_zero;
    logic d_inf;
    logic d_valid;

    // Align-add to normalize
    sum_t s_frac;
    scale_t s_scale;
    logic s_sign;
    logic s_zero;
    logic s_inf;
    logic s_valid;

    posit_decode #(
        .N(N),
        .ES(ES)
    ) i_decode (
        .aclk(aclk),
        .rst_i(rst_i),
        .a_i(a_i),
        .b_i(b_i),
        .start_i(start_i),
        .lg_sign_o(d_lg_sign),
        .op_add_o(d_op_add),
        .lg_rc_o(d_lg_rc),
        .lg_regime_o(d_lg_regime),
        .lg_exp_o(d_lg_exp),
        .lg_frac_o(d_lg_frac),
        .sm_rc_o(d_sm_rc),
        .sm_regime_o(d_sm_regime),
        .sm_exp_o(d_sm_exp),
        .sm_frac_o(d_sm_frac),
        .zero_o(d_zero),
        .inf_o(d_inf),
        .valid_o(d_valid)
    );

    posit_align_add #(
        .N(N),
        .ES(ES)
    ) i_align_add (
        .aclk(aclk),
        .rst_i(rst_i),
        .lg_sign_i(d_lg_sign),
        .op_add_i(d_op_add),
        .lg_rc_i(d_lg_rc),
        .lg_regime_i(d_lg_regime),
        .lg_exp_i(d_lg_exp),
        .lg_frac_i(d_lg_frac),
        .sm_rc_i(d_sm_rc),
        .sm_regime_i(d_sm_regime),
        .sm_exp_i(d_sm_exp),
        .sm_frac_i(d_sm_frac),
        .zero_i(d_zero),
        .inf_i(d_inf),
        .valid_i(d_valid),
        .sum_frac_o(s_frac),
        .lg_scale_o(s_scale),
        .sign_o(s_sign),
        .zero_o(s_zero),
        .inf_o(s_inf),
        .valid_o(s_valid)
    );

    // Outputs of this stage are the adder outputs
    posit_normalize #(
        .N(N),
        .ES(ES)
    ) i_normalize (
        .aclk(aclk),
        .rst_i(rst_i),
        .sum_frac_i(s_frac),
        .lg_scale_i(s_scale),
        .sign_i(s_sign),
        .zero_i(s_zero),
        .inf_i(s_inf),
        .valid_i(s_valid),
        .sum_o(sum_o),
        .zero_o(zero_o),
        .inf_o(inf_o),
        .done_o(done_o)
    );

endmodule

// ==== posit_add/posit_normalize.sv ====
module posit_normalize
    import posit_pkg::*;
#(
    parameter int N = POSIT_N_DEF,
    parameter int ES = POSIT_ES_DEF,
    localparam int BS = $clog2(N)
)
(
    input  logic                    aclk,
    input  logic                    rst_i,
    input  logic [N-ES+1:0]         sum_frac_i,
    input  logic signed [ES+BS+1:0] lg_scale_i,
    input  logic                    sign_i,
    input  logic                    zero_i,
    input  logic                    inf_i,
    input  logic                    valid_i,
    output logic [N-1:0]            sum_o,
    output logic                    zero_o,
    output logic                    inf_o,
    output logic                    done_o
);

    // Sum width with carry, packed word width
    localparam int SW = N - ES + 2;
    localparam int PW = N + 3;

    typedef logic [N-1:0] posit_t;
    typedef logic [BS-1:0] run_t;
    typedef logic [ES-1:0] exp_t;
    typedef logic [N-ES+1:0] sum_t;
    typedef logic [N-ES:0] frac_t;
    typedef logic signed [ES+BS+1:0] scale_t;
    typedef logic [$clog2(SW)-1:0] lz_t;

    // Stage 1
    lz_t lz;
    sum_t norm;
    scale_t scale_n;
    frac_t frac_q;
    scale_t scale_q;
    logic sign_q;
    logic fz_q;
    logic zero_q;
    logic inf_q;
    logic [NORM_LAT-1:0] vld_q;

    // Stage 2
    scale_t k;
    logic k_pos;
    scale_t run_full;
    run_t run;
    logic signed [PW-1:0] pack_w;
    logic signed [PW-1:0] pack_sh;
    posit_t mag;
    posit_t word;

    // Zeros above the leading one
    function automatic lz_t lead_zeros(input sum_t s);
        logic found;
        lz_t n;
        found = 1'b0;
        n = '0;
        for (int i = SW - 1; i >= 0; i--)
        begin
            if (!found && s[i])
            begin
                n = lz_t'(SW - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign lz = lead_zeros(sum_frac_i);
    assign norm = sum_frac_i << lz;

    // Hidden bit sits one below the carry, so a carry gives plus one
    assign scale_n = lg_scale_i + scale_t'(1) - scale_t'(lz);

    always_ff @(posedge aclk)
    begin
        // Leading one itself is implied
        frac_q <= norm[SW-2:0];
        scale_q <= scale_n;
        sign_q <= sign_i;
        fz_q <= sum_frac_i == '0;
        zero_q <= zero_i;
        inf_q <= inf_i;
    end

    // Split scale, floor division keeps e positive
    assign k = scale_q >>> ES;
    assign k_pos = ~k[$bits(scale_t)-1];

    // Regime length, k+1 ones or -k zeros
    assign run_full = k_pos ? k + scale_t'(1) : -k;
    assign run = (run_full > scale_t'(N - 1)) ? run_t'(N - 1) : run_t'(run_full);

    // Top two bits start the run and end it
    assign pack_w = {k_pos, ~k_pos, exp_t'(scale_q), frac_q};

    // Sign fill stretches the run, low bits fall off
    assign pack_sh = pack_w >>> (run - 1'b1);
    assign mag = {1'b0, pack_sh[PW-1 -: N-1]};
    assign word = sign_q ? -mag : mag;

    always_ff @(posedge aclk)
    begin
        if (inf_q)
        begin
            sum_o <= {1'b1, {(N-1){1'b0}}};
        end
        else if (zero_q || fz_q)
        begin
            sum_o <= '0;
        end
        else
        begin
            sum_o <= word;
        end
        zero_o <= zero_q;
        inf_o <= inf_q;
    end

    always_ff @(posedge aclk)
    begin
        if (rst_i)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[NORM_LAT-2:0], valid_i};
        end
    end

    assign done_o = vld_q[NORM_LAT-1];

    // Zero flag from decode must land on a clean zero result
    a_zero_sum: assert property (@(posedge aclk) disable iff (rst_i)
        zero_o |-> sum_o == '0 && !inf_o);

endmodule

// ==== posit_add/posit_align_add.sv ====
module posit_align_add
    import posit_pkg::*;
#(
    parameter int N = POSIT_N_DEF,
    parameter int ES = POSIT_ES_DEF,
    localparam int BS = $clog2(N)
)
(
    input  logic                   aclk,
    input  logic                   rst_i,
    input  logic                   lg_sign_i,
    input  logic                   op_add_i,
    input  logic                   lg_rc_i,
    input  logic [BS-1:0]          lg_regime_i,
    input  logic [ES-1:0]          lg_exp_i,
    input  logic [N-ES:0]          lg_frac_i,
    input  logic                   sm_rc_i,
    input  logic [BS-1:0]          sm_regime_i,
    input  logic [ES-1:0]          sm_exp_i,
    input  logic [N-ES:0]          sm_frac_i,
    input  logic                   zero_i,
    input  logic                   inf_i,
    input  logic                   valid_i,
    output logic [N-ES+1:0]        sum_frac_o,
    output logic signed [ES+BS+1:0] lg_scale_o,
    output logic                   sign_o,
    output logic                   zero_o,
    output logic                   inf_o,
    output logic                   valid_o
);

    // Fraction width, also the largest useful shift
    localparam int FW = N - ES + 1;
    localparam int SHW = $clog2(FW + 1);

    typedef logic [BS-1:0] run_t;
    typedef logic [ES-1:0] exp_t;
    typedef logic [N-ES:0] frac_t;
    typedef logic [N-ES+1:0] sum_t;
    typedef logic signed [ES+BS+1:0] scale_t;
    typedef logic [SHW-1:0] shamt_t;

    scale_t lg_scale;
    scale_t sm_scale;
    scale_t scale_diff;
    shamt_t shamt;

    // Stage 1
    frac_t lg_frac_q;
    frac_t sm_frac_q;
    shamt_t shamt_q;
    scale_t lg_scale_q;
    logic op_add_q;
    logic sign_q;
    logic zero_q;
    logic inf_q;
    logic [ALIGN_LAT-1:0] vld_q;

    // Stage 2
    frac_t sm_shift;
    frac_t drop_mask;
    logic sticky;
    sum_t sum_c;

    // Scale is k * 2^ES + e, k from the regime run
    function automatic scale_t to_scale(input logic rc, input run_t run, input exp_t e);
        scale_t k;
        k = rc ? scale_t'(run) - scale_t'(1) : -scale_t'(run);
        return (k <<< ES) + scale_t'(e);
    endfunction

    assign lg_scale = to_scale(lg_rc_i, lg_regime_i, lg_exp_i);
    assign sm_scale = to_scale(sm_rc_i, sm_regime_i, sm_exp_i);
    assign scale_diff = lg_scale - sm_scale;

    // Beyond FW the small fraction is gone entirely
    assign shamt = (scale_diff > scale_t'(FW)) ? shamt_t'(FW) : shamt_t'(scale_diff);

    always_ff @(posedge aclk)
    begin
        lg_frac_q <= lg_frac_i;
        sm_frac_q <= sm_frac_i;
        shamt_q <= shamt;
        lg_scale_q <= lg_scale;
        op_add_q <= op_add_i;
        sign_q <= lg_sign_i;
        zero_q <= zero_i;
        inf_q <= inf_i;
    end

    // Align small fraction
    assign sm_shift = sm_frac_q >> shamt_q;
    assign drop_mask = ~(frac_t'('1) << shamt_q);
    assign sticky = |(sm_frac_q & drop_mask);

    // Lost bits on a subtract pull the difference one step down,
    // which keeps the later truncation exact
    assign sum_c = op_add_q ? sum_t'(lg_frac_q) + sum_t'(sm_shift)
                            : sum_t'(lg_frac_q) - sum_t'(sm_shift) - sum_t'(sticky);

    always_ff @(posedge aclk)
    begin
        sum_frac_o <= sum_c;
        lg_scale_o <= lg_scale_q;
        sign_o <= sign_q;
        zero_o <= zero_q;
        inf_o <= inf_q;
    end

    always_ff @(posedge aclk)
    begin
        if (rst_i)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[ALIGN_LAT-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[ALIGN_LAT-1];

    // Relies on the magnitude ordering done in decode
    a_diff_pos: assert property (@(posedge aclk) disable iff (rst_i)
        valid_i && !zero_i && !inf_i |-> scale_diff >= 0);

endmodule

// ==== posit_add/posit_decode.sv ====
module posit_decode
    import posit_pkg::*;
#(
    parameter int N = POSIT_N_DEF,
    parameter int ES = POSIT_ES_DEF,
    localparam int BS = $clog2(N)
)
(
    input  logic          aclk,
    input  logic          rst_i,
    input  logic [N-1:0]  a_i,
    input  logic [N-1:0]  b_i,
    input  logic          start_i,
    output logic          lg_sign_o,
    output logic          op_add_o,
    output logic          lg_rc_o,
    output logic [BS-1:0] lg_regime_o,
    output logic [ES-1:0] lg_exp_o,
    output logic [N-ES:0] lg_frac_o,
    output logic          sm_rc_o,
    output logic [BS-1:0] sm_regime_o,
    output logic [ES-1:0] sm_exp_o,
    output logic [N-ES:0] sm_frac_o,
    output logic          zero_o,
    output logic          inf_o,
    output logic          valid_o
);

    typedef logic [N-1:0] posit_t;
    typedef logic [BS-1:0] run_t;
    typedef logic [ES-1:0] exp_t;
    typedef logic [N-ES:0] frac_t;

    // Stage 1, raw operands and their flags
    posit_t a_q;
    posit_t b_q;
    logic a_sign_q;
    logic b_sign_q;
    logic a_nz_q;
    logic b_nz_q;
    logic a_nar_q;
    logic b_nar_q;

    // Strobe chain
    logic [DECODE_LAT-1:0] vld_q;

    // Stage 2, field extraction
    posit_t a_abs;
    posit_t b_abs;
    run_t a_run;
    run_t b_run;
    logic [N-2:0] a_rest;
    logic [N-2:0] b_rest;
    frac_t a_frac;
    frac_t b_frac;
    logic a_ge_b;

    // Length of the regime run, counted from below the sign bit
    function automatic run_t count_run(input posit_t x);
        logic rc;
        logic run_end;
        run_t n;
        rc = x[N-2];
        run_end = 1'b0;
        n = '0;
        for (int i = N - 2; i >= 0; i--)
        begin
            if (!run_end && x[i] == rc)
            begin
                n = n + 1'b1;
            end
            else
            begin
                run_end = 1'b1;
            end
        end
        return n;
    endfunction

    always_ff @(posedge aclk)
    begin
        a_q <= a_i;
        b_q <= b_i;
        a_sign_q <= a_i[N-1];
        b_sign_q <= b_i[N-1];
        a_nz_q <= |a_i[N-2:0];
        b_nz_q <= |b_i[N-2:0];
        // NaR is the sign bit alone
        a_nar_q <= a_i[N-1] & ~(|a_i[N-2:0]);
        b_nar_q <= b_i[N-1] & ~(|b_i[N-2:0]);
    end

    // Negative posits are decoded from their two's complement
    assign a_abs = a_sign_q ? -a_q : a_q;
    assign b_abs = b_sign_q ? -b_q : b_q;

    assign a_run = count_run(a_abs);
    assign b_run = count_run(b_abs);

    // Drop regime run and its terminating bit, exponent is then on top
    assign a_rest = a_abs[N-2:0] << (int'(a_run) + 1);
    assign b_rest = b_abs[N-2:0] << (int'(b_run) + 1);

    // Hidden bit, fraction, one guard bit for the alignment shift
    assign a_frac = {a_nz_q, a_rest[N-2-ES:0], 1'b0};
    assign b_frac = {b_nz_q, b_rest[N-2-ES:0], 1'b0};

    // Posit order follows the bit pattern of the magnitude
    assign a_ge_b = a_abs[N-2:0] >= b_abs[N-2:0];

    always_ff @(posedge aclk)
    begin
        lg_sign_o <= a_ge_b ? a_sign_q : b_sign_q;
        op_add_o <= a_sign_q == b_sign_q;
        lg_rc_o <= a_ge_b ? a_abs[N-2] : b_abs[N-2];
        lg_regime_o <= a_ge_b ? a_run : b_run;
        lg_exp_o <= a_ge_b ? a_rest[N-2 -: ES] : b_rest[N-2 -: ES];
        lg_frac_o <= a_ge_b ? a_frac : b_frac;
        sm_rc_o <= a_ge_b ? b_abs[N-2] : a_abs[N-2];
        sm_regime_o <= a_ge_b ? b_run : a_run;
        sm_exp_o <= a_ge_b ? b_rest[N-2 -: ES] : a_rest[N-2 -: ES];
        sm_frac_o <= a_ge_b ? b_frac : a_frac;
        // Both operands zero
        zero_o <= ~(a_sign_q | a_nz_q | b_sign_q | b_nz_q);
        inf_o <= a_nar_q | b_nar_q;
    end

    always_ff @(posedge aclk)
    begin
        if (rst_i)
        begin
            vld_q <= '0;
        end
        else
        begin
            vld_q <= {vld_q[DECODE_LAT-2:0], start_i};
        end
    end

    assign valid_o = vld_q[DECODE_LAT-1];

    // A zero operand is never NaR, so the flags exclude each other
    a_flags_excl: assert property (@(posedge aclk) disable iff (rst_i)
        !(zero_o && inf_o));

endmodule

// ==== common/posit_pkg.sv ====
package posit_pkg;

    // Default posit format, overridden from the top level
    parameter int POSIT_N_DEF = 8;
    parameter int POSIT_ES_DEF = 2;

    // Register stages per block
    // Every block is two registers deep, the strobe chains follow these
    parameter int DECODE_LAT = 2;
    parameter int ALIGN_LAT = 2;
    parameter int NORM_LAT = 2;

    // Start to done, in cycles
    parameter int ADD_LAT = DECODE_LAT + ALIGN_LAT + NORM_LAT;

endpackage
